// File: compile.f
+incdir+include
hdl/cpu_pkg.sv
hdl/dispatch_if.sv
hdl/rob_issue_if.sv
hdl/mem_ctrler.sv
hdl/inst_fetcher.sv
hdl/issuer.sv
hdl/reg_file.sv
hdl/rs_station.sv
hdl/ro_buffer.sv
hdl/cpu.sv
testbench/tb_cpu.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      = tb_cpu
FILELIST = compile.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then \
	  echo "fail message found in $(LOG)"; exit 1; \
	fi
	@grep -q "Simulation PASSED" $(LOG) || (echo "no pass message in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

// File: testbench/tb_cpu.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module tb_cpu;
  import cpu_pkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int DRIVE_DELAY = 2;
  localparam int RESET_CYCLES = 8;
  localparam int MEM_BYTES = 256;
  localparam word_t NOP = 32'h0000_0013;

  logic clk_in;
  logic rst_in;
  logic rdy_in;
  byte_t mem_din;
  addr_t mem_a;
  logic commit_valid;
  reg_id_t commit_rd;
  word_t commit_value;

  byte_t mem [MEM_BYTES];
  addr_t mem_a_seen;
  word_t prog_q [$];
  reg_id_t rd_q [$];
  word_t value_q [$];
  integer seed;
  int reset_left;
  logic pause_on;
  int commits_seen;
  int pass_no;

  cpu cpu_inst (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .rdy_in(rdy_in),
    .mem_din(mem_din),
    .mem_a(mem_a),
    .commit_valid(commit_valid),
    .commit_rd(commit_rd),
    .commit_value(commit_value)
  );

  always #(CLK_PERIOD / 2) clk_in = ~clk_in;

  // instruction encoders
  function automatic word_t enc_u(input int rd, input int imm20);
    enc_u = {imm20[19:0], rd[4:0], 7'b0110111};
  endfunction

  function automatic word_t enc_i(input int rd, input int f3, input int rs1, input int imm);
    enc_i = {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0010011};
  endfunction

  function automatic word_t enc_r(input int rd, input int f3, input int rs1, input int rs2,
                                  input int f7);
    enc_r = {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
  endfunction

  task automatic add_entry(input word_t w, input int rd, input word_t v);
    prog_q.push_back(w);
    rd_q.push_back(reg_id_t'(rd));
    value_q.push_back(v);
  endtask

  // program space with NOPs past the end
  function automatic byte_t mem_byte(input addr_t a);
    if (a < addr_t'(prog_q.size() * 4)) begin
      mem_byte = mem[a[7:0]];
    end else begin
      mem_byte = NOP[8 * a[1:0] +: 8];
    end
  endfunction

  task automatic check_rd(input reg_id_t got, input reg_id_t exp, input string what);
    if (got !== exp) begin
      $display("Error at %0t: %s, got x%0d, expected x%0d", $time, what, got, exp);
      $display("Simulation FAILED");
      $fatal(1, "commit rd mismatch");
    end
  endtask

  task automatic check_value(input word_t got, input word_t exp, input string what);
    if (got !== exp) begin
      $display("Error at %0t: %s, got %h, expected %h", $time, what, got, exp);
      $display("Simulation FAILED");
      $fatal(1, "commit value mismatch");
    end
  endtask

  task automatic check_addr(input addr_t got, input addr_t exp, input string what);
    if (got !== exp) begin
      $display("Error at %0t: %s, got %h, expected %h", $time, what, got, exp);
      $display("Simulation FAILED");
      $fatal(1, "memory address mismatch");
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("Error at %0t: %s, got %b, expected %b", $time, what, got, exp);
      $display("Simulation FAILED");
      $fatal(1, "control flag mismatch");
    end
  endtask

  // memory answers one cycle late and inputs change just after the edge
  always @(negedge clk_in) begin
    mem_a_seen <= mem_a;
  end

  always @(posedge clk_in) begin
    #(DRIVE_DELAY);
    mem_din = mem_byte(mem_a_seen);
    if (reset_left != 0) begin
      rst_in = 1'b1;
      reset_left--;
    end else begin
      rst_in = 1'b0;
    end
    if (rst_in || !pause_on) begin
      rdy_in = 1'b1;
    end else begin
      rdy_in = (($random(seed) & 3) != 0);
    end
  end

  task automatic apply_reset(input logic pause);
    @(negedge clk_in);
    pause_on = pause;
    if (!rst_in) begin
      reset_left = RESET_CYCLES;
    end
    @(negedge clk_in);
    while (rst_in) begin
      @(negedge clk_in);
      if (rst_in) begin
        check_flag(commit_valid, 1'b0, "commit_valid during reset");
      end
    end
  endtask

  task automatic run_program();
    int seen;
    addr_t last_a;
    commits_seen = 0;
    seen = 0;
    last_a = '0;
    while (commits_seen < prog_q.size()) begin
      @(negedge clk_in);
      // first word fetch walks up byte by byte
      if (seen == 0) begin
        check_addr(mem_a, `CPU_RESET_PC, "first byte address");
        last_a = mem_a;
        seen = 1;
      end else if (seen < `CPU_WORD_BYTES && mem_a != last_a) begin
        check_addr(mem_a, last_a + 32'd1, "next byte address");
        last_a = mem_a;
        seen++;
      end
      if (commit_valid) begin
        check_rd(commit_rd, rd_q[commits_seen], $sformatf("entry %0d rd", commits_seen));
        check_value(commit_value, value_q[commits_seen],
                    $sformatf("entry %0d value", commits_seen));
        commits_seen++;
      end
    end
  endtask

  initial begin
    word_t w;
    clk_in = 1'b0;
    rst_in = 1'b1;
    rdy_in = 1'b1;
    mem_din = '0;
    seed = 32'h312a;
    reset_left = RESET_CYCLES - 1;
    pause_on = 1'b0;
    commits_seen = 0;
    pass_no = 0;

    // independent LUI and OP-IMM
    add_entry(enc_u(1, 'h12345), 1, 32'h1234_5000);
    add_entry(enc_i(2, 0, 0, 100), 2, 32'd100);
    add_entry(enc_i(3, 0, 0, -1), 3, 32'hffff_ffff);
    add_entry(enc_i(4, 4, 0, 'h55), 4, 32'h0000_0055);
    // x1 renamed twice while in flight
    add_entry(enc_i(1, 0, 1, 'h678), 1, 32'h1234_5678);
    add_entry(enc_i(1, 0, 1, 1), 1, 32'h1234_5679);
    add_entry(enc_r(5, 0, 1, 2, 0), 5, 32'h1234_56dd);
    add_entry(enc_r(6, 0, 2, 1, 'h20), 6, 32'hedcb_a9eb);
    add_entry(enc_i(7, 0, 0, 4), 7, 32'd4);
    add_entry(enc_r(8, 1, 1, 7, 0), 8, 32'h2345_6790);
    add_entry(enc_u(9, 'h80000), 9, 32'h8000_0000);
    add_entry(enc_i(9, 0, 9, 'h0f0), 9, 32'h8000_00f0);
    add_entry(enc_r(10, 5, 9, 7, 0), 10, 32'h0800_000f);
    add_entry(enc_r(11, 5, 9, 7, 'h20), 11, 32'hf800_000f);
    add_entry(enc_r(12, 2, 9, 2, 0), 12, 32'd1);
    add_entry(enc_r(13, 3, 9, 2, 0), 13, 32'd0);
    add_entry(enc_r(14, 3, 2, 3, 0), 14, 32'd1);
    // x0 result shows on the commit port only
    add_entry(enc_i(0, 0, 2, 5), 0, 32'd105);
    add_entry(enc_r(15, 0, 0, 2, 0), 15, 32'd100);
    // chain longer than the rob
    add_entry(enc_i(16, 0, 0, 1), 16, 32'd1);
    add_entry(enc_r(16, 0, 16, 16, 0), 16, 32'd2);
    add_entry(enc_r(16, 0, 16, 16, 0), 16, 32'd4);
    add_entry(enc_r(16, 0, 16, 16, 0), 16, 32'd8);
    add_entry(enc_r(16, 0, 16, 16, 0), 16, 32'd16);
    add_entry(enc_i(16, 0, 16, -3), 16, 32'd13);
    add_entry(enc_r(17, 6, 16, 4, 0), 17, 32'h0000_005d);
    add_entry(enc_i(18, 7, 17, 'h0f), 18, 32'h0000_000d);
    add_entry(enc_i(19, 5, 3, 'h408), 19, 32'hffff_ffff);
    add_entry(enc_i(20, 5, 9, 31), 20, 32'd1);
    add_entry(enc_i(21, 2, 3, 0), 21, 32'd1);
    add_entry(enc_i(22, 1, 2, 2), 22, 32'h0000_0190);

    for (int i = 0; i < prog_q.size(); i++) begin
      w = prog_q[i];
      for (int b = 0; b < `CPU_WORD_BYTES; b++) begin
        mem[8'(4 * i + b)] = w[8 * b +: 8];
      end
    end

    // same program without and with rdy_in pauses
    for (int p = 0; p < 2; p++) begin
      pass_no = p;
      apply_reset(p == 1);
      run_program();
    end

    $display("Simulation PASSED");
    $finish;
  end

  initial begin
    int limit_ns;
    #1;
    limit_ns = 2 * (prog_q.size() * 20 * CLK_PERIOD + (RESET_CYCLES + 2) * CLK_PERIOD);
    #(limit_ns);
    $display("Timeout: commits stopped arriving, %0d of %0d seen in pass %0d",
             commits_seen, prog_q.size(), pass_no);
    $display("Simulation FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

// File: hdl/cpu.sv
`timescale 1ns/1ps

module cpu (
  input  logic              clk_in,
  input  logic              rst_in,
  input  logic              rdy_in,
  input  cpu_pkg::byte_t    mem_din,
  output cpu_pkg::addr_t    mem_a,
  output logic              commit_valid,
  output cpu_pkg::reg_id_t  commit_rd,
  output cpu_pkg::word_t    commit_value
);
  import cpu_pkg::*;

  logic fetch_req;
  addr_t fetch_addr;
  logic fetch_done;
  word_t fetch_word;
  logic inst_valid;
  word_t inst;
  addr_t inst_pc;
  logic inst_take;
  reg_id_t rs1;
  reg_id_t rs2;
  reg_id_t rd_alloc;
  logic alloc_we;
  logic busy1;
  rob_id_t tag1;
  word_t value1;
  logic busy2;
  rob_id_t tag2;
  word_t value2;
  // single result bus
  logic cdb_valid;
  rob_id_t cdb_tag;
  word_t cdb_value;
  rob_id_t commit_tag;

  dispatch_if disp ();
  rob_issue_if rob ();

  mem_ctrler mem_ctrler_inst (.*);

  inst_fetcher inst_fetcher_inst (.*);

  issuer issuer_inst (.disp(disp), .rob(rob), .*);

  reg_file reg_file_inst (.alloc_tag(rob.alloc_tag), .*);

  rs_station rs_station_inst (.disp(disp), .*);

  ro_buffer ro_buffer_inst (.rob(rob), .*);

endmodule

// File: hdl/ro_buffer.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module ro_buffer (
  input  logic              clk_in,
  input  logic              rst_in,
  input  logic              rdy_in,
  rob_issue_if.rob          rob,
  input  logic              cdb_valid,
  input  cpu_pkg::rob_id_t  cdb_tag,
  input  cpu_pkg::word_t    cdb_value,
  output logic              commit_valid,
  output cpu_pkg::rob_id_t  commit_tag,
  output cpu_pkg::reg_id_t  commit_rd,
  output cpu_pkg::word_t    commit_value
);
  import cpu_pkg::*;

  localparam int DEPTH = `CPU_ROB_DEPTH;
  localparam int CNT_W = $clog2(DEPTH) + 1;

  rob_id_t head;
  rob_id_t tail;
  logic [CNT_W-1:0] count;
  logic [DEPTH-1:0] done;
  logic [DEPTH-1:0] in_use;
  reg_id_t rd [DEPTH];
  word_t value [DEPTH];
  logic alloc;

  assign rob.full = count == CNT_W'(DEPTH);
  assign rob.alloc_tag = tail;
  assign alloc = rob.alloc_valid && !rob.full && rdy_in;

  assign rob.qj_done = done[rob.qj];
  assign rob.qj_value = value[rob.qj];
  assign rob.qk_done = done[rob.qk];
  assign rob.qk_value = value[rob.qk];

  // entry is live when it sits less than count slots past head
  always_comb begin
    rob_id_t offset;
    for (int i = 0; i < DEPTH; i++) begin
      offset = rob_id_t'(i) - head;
      in_use[i] = {1'b0, offset} < count;
    end
  end

  assign commit_valid = rdy_in && count != '0 && done[head];
  assign commit_tag = head;
  assign commit_rd = rd[head];
  assign commit_value = value[head];

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      head <= '0;
      tail <= '0;
      count <= '0;
      done <= '0;
    end else if (rdy_in) begin
      if (cdb_valid) begin
        done[cdb_tag] <= 1'b1;
      end
      if (alloc) begin
        done[tail] <= 1'b0;
        tail <= tail + 1'b1;
      end
      if (commit_valid) begin
        head <= head + 1'b1;
      end
      count <= count + CNT_W'(alloc) - CNT_W'(commit_valid);
    end
  end

  always_ff @(posedge clk_in) begin
    if (rdy_in) begin
      if (alloc) begin
        rd[tail] <= rob.alloc_rd;
      end
      if (cdb_valid) begin
        value[cdb_tag] <= cdb_value;
      end
    end
  end

  // an allocation never lands on a live entry
  a_alloc_free_slot: assert property (@(posedge clk_in) disable iff (rst_in)
    alloc |-> !in_use[tail]);

  // each result lands once in a live entry
  a_capture_live: assert property (@(posedge clk_in) disable iff (rst_in)
    cdb_valid |-> in_use[cdb_tag] && !done[cdb_tag]);

endmodule

// File: hdl/rs_station.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module rs_station (
  input  logic              clk_in,
  input  logic              rst_in,
  input  logic              rdy_in,
  dispatch_if.station       disp,
  output logic              cdb_valid,
  output cpu_pkg::rob_id_t  cdb_tag,
  output cpu_pkg::word_t    cdb_value
);
  import cpu_pkg::*;

  localparam int DEPTH = `CPU_RS_DEPTH;
  localparam int IDX_W = $clog2(DEPTH);

  logic [DEPTH-1:0] valid;
  logic [DEPTH-1:0] rj;
  logic [DEPTH-1:0] rk;
  alu_op_t op [DEPTH];
  word_t vj [DEPTH];
  word_t vk [DEPTH];
  rob_id_t qj [DEPTH];
  rob_id_t qk [DEPTH];
  rob_id_t dest [DEPTH];
  // inserts seen since this entry arrived
  logic [IDX_W-1:0] age [DEPTH];

  logic sel_found;
  logic [IDX_W-1:0] sel_idx;
  logic [IDX_W-1:0] free_idx;
  logic accept;

  function automatic word_t alu(input alu_op_t f, input word_t a, input word_t b);
    case (f)
      ADD: alu = a + b;
      SUB: alu = a - b;
      AND: alu = a & b;
      OR: alu = a | b;
      XOR: alu = a ^ b;
      SLL: alu = a << b[4:0];
      SRL: alu = a >> b[4:0];
      SRA: alu = word_t'($signed(a) >>> b[4:0]);
      SLT: alu = {31'b0, $signed(a) < $signed(b)};
      SLTU: alu = {31'b0, a < b};
      default: alu = b;
    endcase
  endfunction

  // oldest entry with both operands in hand
  always_comb begin
    sel_found = 1'b0;
    sel_idx = '0;
    for (int i = 0; i < DEPTH; i++) begin
      if (valid[i] && rj[i] && rk[i] && (!sel_found || age[i] > age[sel_idx])) begin
        sel_found = 1'b1;
        sel_idx = IDX_W'(i);
      end
    end
  end

  always_comb begin
    free_idx = '0;
    for (int i = DEPTH - 1; i >= 0; i--) begin
      if (!valid[i]) begin
        free_idx = IDX_W'(i);
      end
    end
  end

  assign disp.full = &valid;
  assign accept = disp.valid && !disp.full && rdy_in;

  assign cdb_valid = sel_found && rdy_in;
  assign cdb_tag = dest[sel_idx];
  assign cdb_value = alu(op[sel_idx], vj[sel_idx], vk[sel_idx]);

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      valid <= '0;
    end else if (rdy_in) begin
      if (cdb_valid) begin
        valid[sel_idx] <= 1'b0;
      end
      if (accept) begin
        valid[free_idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (rdy_in) begin
      for (int i = 0; i < DEPTH; i++) begin
        // wakeup from our own broadcast
        if (cdb_valid && !rj[i] && qj[i] == cdb_tag) begin
          vj[i] <= cdb_value;
          rj[i] <= 1'b1;
        end
        if (cdb_valid && !rk[i] && qk[i] == cdb_tag) begin
          vk[i] <= cdb_value;
          rk[i] <= 1'b1;
        end
        if (accept && valid[i] && age[i] != '1) begin
          age[i] <= age[i] + 1'b1;
        end
      end
      if (accept) begin
        op[free_idx] <= disp.op;
        vj[free_idx] <= disp.vj;
        vk[free_idx] <= disp.vk;
        rj[free_idx] <= disp.vj_ready;
        rk[free_idx] <= disp.vk_ready;
        qj[free_idx] <= disp.qj;
        qk[free_idx] <= disp.qk;
        dest[free_idx] <= disp.dest;
        age[free_idx] <= '0;
      end
    end
  end

endmodule

// File: hdl/reg_file.sv
`timescale 1ns/1ps

module reg_file (
  input  logic              clk_in,
  input  logic              rst_in,
  input  logic              rdy_in,
  input  cpu_pkg::reg_id_t  rs1,
  input  cpu_pkg::reg_id_t  rs2,
  input  cpu_pkg::reg_id_t  rd_alloc,
  input  logic              alloc_we,
  input  cpu_pkg::rob_id_t  alloc_tag,
  output logic              busy1,
  output cpu_pkg::rob_id_t  tag1,
  output cpu_pkg::word_t    value1,
  output logic              busy2,
  output cpu_pkg::rob_id_t  tag2,
  output cpu_pkg::word_t    value2,
  input  logic              commit_valid,
  input  cpu_pkg::rob_id_t  commit_tag,
  input  cpu_pkg::reg_id_t  commit_rd,
  input  cpu_pkg::word_t    commit_value
);
  import cpu_pkg::*;

  word_t regs [32];
  rob_id_t tags [32];
  logic [31:0] busy;

  // x0 is never renamed so busy[0] stays clear
  assign busy1 = busy[rs1];
  assign tag1 = tags[rs1];
  assign value1 = (rs1 == '0) ? '0 : regs[rs1];
  assign busy2 = busy[rs2];
  assign tag2 = tags[rs2];
  assign value2 = (rs2 == '0) ? '0 : regs[rs2];

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      busy <= '0;
    end else if (rdy_in) begin
      // only the newest writer releases the register
      if (commit_valid && commit_rd != '0 && tags[commit_rd] == commit_tag) begin
        busy[commit_rd] <= 1'b0;
      end
      if (alloc_we && rd_alloc != '0) begin
        busy[rd_alloc] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (rdy_in) begin
      if (commit_valid && commit_rd != '0) begin
        regs[commit_rd] <= commit_value;
      end
      if (alloc_we && rd_alloc != '0) begin
        tags[rd_alloc] <= alloc_tag;
      end
    end
  end

endmodule

// File: hdl/issuer.sv
`timescale 1ns/1ps

module issuer (
  input  logic              clk_in,
  input  logic              rst_in,
  input  logic              rdy_in,
  input  logic              inst_valid,
  input  cpu_pkg::word_t    inst,
  input  cpu_pkg::addr_t    inst_pc,
  output logic              inst_take,
  output cpu_pkg::reg_id_t  rs1,
  output cpu_pkg::reg_id_t  rs2,
  output cpu_pkg::reg_id_t  rd_alloc,
  output logic              alloc_we,
  input  logic              busy1,
  input  cpu_pkg::rob_id_t  tag1,
  input  cpu_pkg::word_t    value1,
  input  logic              busy2,
  input  cpu_pkg::rob_id_t  tag2,
  input  cpu_pkg::word_t    value2,
  input  logic              cdb_valid,
  input  cpu_pkg::rob_id_t  cdb_tag,
  input  cpu_pkg::word_t    cdb_value,
  dispatch_if.issuer        disp,
  rob_issue_if.issuer       rob
);
  import cpu_pkg::*;

  localparam logic [6:0] OPC_LUI = 7'b0110111;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP = 7'b0110011;

  logic [6:0] opcode;
  logic is_lui;
  logic is_op;
  reg_id_t rd;
  word_t imm;
  alu_op_t op;
  logic j_ready;
  logic k_ready;
  word_t j_val;
  word_t k_val;
  logic go;

  // register file, then a done rob entry, then this cycle's result bus
  function automatic logic resolve(input logic busy, input rob_id_t tag, input word_t rf_val,
                                   input logic rob_done, input word_t rob_val,
                                   output word_t val);
    val = rf_val;
    resolve = 1'b1;
    if (busy && rob_done) begin
      val = rob_val;
    end else if (busy && cdb_valid && cdb_tag == tag) begin
      val = cdb_value;
    end else if (busy) begin
      resolve = 1'b0;
    end
  endfunction

  assign opcode = inst[6:0];
  assign is_lui = opcode == OPC_LUI;
  assign is_op = opcode == OPC_OP;
  assign rd = inst[11:7];
  assign rs1 = inst[19:15];
  assign rs2 = inst[24:20];
  assign imm = is_lui ? {inst[31:12], 12'b0} : {{20{inst[31]}}, inst[31:20]};

  always_comb begin
    case (inst[14:12])
      3'b000: op = (is_op && inst[30]) ? SUB : ADD;
      3'b001: op = SLL;
      3'b010: op = SLT;
      3'b011: op = SLTU;
      3'b100: op = XOR;
      3'b101: op = inst[30] ? SRA : SRL;
      3'b110: op = OR;
      default: op = AND;
    endcase
    if (is_lui) begin
      op = PASS_B;
    end
  end

  always_comb begin
    j_ready = resolve(busy1, tag1, value1, rob.qj_done, rob.qj_value, j_val);
    k_ready = resolve(busy2, tag2, value2, rob.qk_done, rob.qk_value, k_val);
    if (is_lui) begin
      j_ready = 1'b1;
      j_val = '0;
    end
    if (!is_op) begin
      k_ready = 1'b1;
      k_val = imm;
    end
  end

  assign go = inst_valid && !disp.full && !rob.full;
  assign inst_take = go && rdy_in;
  assign alloc_we = inst_take && rd != '0;
  assign rd_alloc = rd;

  assign rob.alloc_valid = inst_valid && !disp.full;
  assign rob.alloc_rd = rd;
  assign rob.qj = tag1;
  assign rob.qk = tag2;

  assign disp.valid = inst_valid && !rob.full;
  assign disp.op = op;
  assign disp.vj = j_val;
  assign disp.vk = k_val;
  assign disp.vj_ready = j_ready;
  assign disp.vk_ready = k_ready;
  assign disp.qj = tag1;
  assign disp.qk = tag2;
  assign disp.dest = rob.alloc_tag;

  a_supported_opcode: assert property (@(posedge clk_in) disable iff (rst_in)
    inst_take |-> (is_lui || is_op || opcode == OPC_OP_IMM))
    else $error("unsupported opcode %b at pc %h", opcode, inst_pc);

endmodule

// File: hdl/inst_fetcher.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module inst_fetcher (
  input  logic            clk_in,
  input  logic            rst_in,
  input  logic            rdy_in,
  output logic            fetch_req,
  output cpu_pkg::addr_t  fetch_addr,
  input  logic            fetch_done,
  input  cpu_pkg::word_t  fetch_word,
  output logic            inst_valid,
  output cpu_pkg::word_t  inst,
  output cpu_pkg::addr_t  inst_pc,
  input  logic            inst_take
);
  import cpu_pkg::*;

  addr_t pc;

  assign fetch_addr = pc;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      pc <= `CPU_RESET_PC;
      fetch_req <= 1'b0;
      inst_valid <= 1'b0;
    end else if (rdy_in) begin
      if (inst_take) begin
        inst_valid <= 1'b0;
      end
      if (fetch_req && fetch_done) begin
        fetch_req <= 1'b0;
        inst_valid <= 1'b1;
        pc <= pc + 32'd4;
      end else if (!fetch_req && (!inst_valid || inst_take)) begin
        // straight-line code without redirect
        fetch_req <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (rdy_in && fetch_req && fetch_done) begin
      inst <= fetch_word;
      inst_pc <= pc;
    end
  end

endmodule

// File: hdl/mem_ctrler.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module mem_ctrler (
  input  logic            clk_in,
  input  logic            rst_in,
  input  logic            rdy_in,
  input  cpu_pkg::byte_t  mem_din,
  output cpu_pkg::addr_t  mem_a,
  input  logic            fetch_req,
  input  cpu_pkg::addr_t  fetch_addr,
  output logic            fetch_done,
  output cpu_pkg::word_t  fetch_word
);
  import cpu_pkg::*;

  localparam int CNT_W = $clog2(`CPU_WORD_BYTES + 1);

  mem_state_t state;
  // byte addresses issued so far
  logic [CNT_W-1:0] cnt;
  logic [CNT_W-1:0] a_idx;
  word_t word;

  // on a pause the address of the byte still owed goes out again
  assign a_idx = (state == READ && !rdy_in) ? cnt - 1'b1 : cnt;
  assign mem_a = fetch_addr + addr_t'(a_idx);
  assign fetch_done = (state == DONE) && rdy_in;
  assign fetch_word = word;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state <= IDLE;
      cnt <= '0;
    end else if (rdy_in) begin
      case (state)
        IDLE: begin
          // byte 0 already went out this cycle
          if (fetch_req) begin
            state <= READ;
            cnt <= CNT_W'(1);
          end
        end
        READ: begin
          if (cnt == CNT_W'(`CPU_WORD_BYTES)) begin
            state <= DONE;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: begin
          state <= IDLE;
          cnt <= '0;
        end
      endcase
    end
  end

  // little endian so the last byte lands on top
  always_ff @(posedge clk_in) begin
    if (rdy_in && state == READ) begin
      word <= {mem_din, word[31:8]};
    end
  end

  a_addr_stable: assert property (@(posedge clk_in) disable iff (rst_in)
    state != IDLE |-> $stable(fetch_addr));

endmodule

// File: hdl/rob_issue_if.sv
`timescale 1ns/1ps

interface rob_issue_if;
  import cpu_pkg::*;

  logic alloc_valid;
  reg_id_t alloc_rd;
  rob_id_t alloc_tag;
  logic full;
  // operand lookup by tag
  rob_id_t qj;
  rob_id_t qk;
  logic qj_done;
  word_t qj_value;
  logic qk_done;
  word_t qk_value;

  modport issuer (output alloc_valid, alloc_rd, qj, qk,
                  input alloc_tag, full, qj_done, qj_value, qk_done, qk_value);
  modport rob (input alloc_valid, alloc_rd, qj, qk,
               output alloc_tag, full, qj_done, qj_value, qk_done, qk_value);

endinterface

// File: hdl/dispatch_if.sv
`timescale 1ns/1ps

interface dispatch_if;
  import cpu_pkg::*;

  logic valid;
  alu_op_t op;
  word_t vj;
  word_t vk;
  logic vj_ready;
  logic vk_ready;
  rob_id_t qj;
  rob_id_t qk;
  rob_id_t dest;
  logic full;

  modport issuer (output valid, op, vj, vk, vj_ready, vk_ready, qj, qk, dest, input full);
  modport station (input valid, op, vj, vk, vj_ready, vk_ready, qj, qk, dest, output full);

endinterface

// File: hdl/cpu_pkg.sv
`include "cpu_config.svh"

package cpu_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;
  typedef logic [7:0] byte_t;
  typedef logic [4:0] reg_id_t;

  // tag of a reorder buffer entry
  typedef logic [$clog2(`CPU_ROB_DEPTH)-1:0] rob_id_t;

  typedef enum logic [3:0] {
    ADD,
    SUB,
    AND,
    OR,
    XOR,
    SLL,
    SRL,
    SRA,
    SLT,
    SLTU,
    PASS_B
  } alu_op_t;

  typedef enum logic [1:0] {
    IDLE,
    READ,
    DONE
  } mem_state_t;

endpackage

// File: include/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// reorder buffer entries as a power of two
`define CPU_ROB_DEPTH 4

`define CPU_RS_DEPTH 4

// first fetch address
`define CPU_RESET_PC 32'h0000_0000

// byte reads per instruction word
`define CPU_WORD_BYTES 4

`endif
